// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_sys_tb
FILELIST  ?= mem_sys.f
BUILD_DIR ?= obj_dir
FLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: mem_sys.f
rtl/mem_pkg.sv
rtl/mem_burst_ctrl.sv
rtl/mem_byte_array.sv
rtl/mem_port_arbiter.sv
rtl/mem_sys.sv
verification/tb_clock_gen.sv
verification/mem_sys_tb.sv

// File: rtl/mem_burst_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Burst controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module mem_burst_ctrl #(
  parameter mem_pkg::addr_t START_ADDR = 32'h8002_0000
) (
  input  logic                  clk,
  input  logic                  reset,
  // Request from the arbiter
  input  logic                  start,
  input  mem_pkg::addr_t        addr,
  input  logic                  rw,
  input  mem_pkg::access_size_t size,
  input  mem_pkg::data_t        wdata_in,
  // Status back to the arbiter
  output logic                  ready,
  output logic                  beat,
  // Beat stream towards the array
  output logic                  beat_rw,
  output mem_pkg::access_size_t beat_size,
  output mem_pkg::addr_t        cur_index,
  output mem_pkg::data_t        wdata,
  output mem_pkg::addr_t        pc
);

  mem_pkg::beat_count_t  remaining;
  mem_pkg::addr_t        index_q;
  logic                  rw_q;
  mem_pkg::access_size_t size_q;
  mem_pkg::data_t        wdata_q;

  // Remaining beat counter, the only control state here
  always_ff @(posedge clk) begin
    if (reset) begin
      remaining <= '0;
    end else if (start) begin
      remaining <= mem_pkg::beats_for_size(size);
    end else if (remaining != '0) begin
      remaining <= remaining - 6'd1;
    end
  end

  // Request attributes and running byte index
  always_ff @(posedge clk) begin
    if (start) begin
      index_q <= addr - START_ADDR;
      rw_q    <= rw;
      size_q  <= size;
    end else if (remaining > 6'd1) begin
      // Step to the next word while more beats follow
      index_q <= index_q + 32'd4;
    end
  end

  // Write data is sampled every cycle, one cycle ahead of its beat
  always_ff @(posedge clk) begin
    wdata_q <= wdata_in;
  end

  // A new request may be taken during the final beat
  assign ready = (remaining <= 6'd1);
  assign beat  = (remaining != '0);

  assign beat_rw   = rw_q;
  assign beat_size = size_q;
  assign cur_index = index_q;
  assign wdata     = wdata_q;

  // Beat address back in the MIPS address space
  assign pc = index_q + START_ADDR;

endmodule

// File: rtl/mem_byte_array.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Big-endian byte storage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module mem_byte_array #(
  parameter int MEM_BYTES = 1024
) (
  input  logic                  clk,
  input  logic                  beat,
  input  logic                  rw,
  input  mem_pkg::access_size_t size,
  input  mem_pkg::addr_t        index,
  input  mem_pkg::data_t        wdata,
  output mem_pkg::data_t        rdata
);

  localparam int IDX_W = $clog2(MEM_BYTES);

  logic [7:0]       mem [MEM_BYTES];
  logic [IDX_W-1:0] idx [4];
  logic [2:0]       nbytes;
  logic [3:0]       lane_en;
  logic [7:0]       lane_data [4];

  // Consecutive byte addresses, wrapping at the top of storage
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      idx[i] = index[IDX_W-1:0] + IDX_W'(i);
    end
  end

  assign nbytes = mem_pkg::bytes_for_size(size);

  // Lane 0 is the lowest address, which holds the most significant byte
  always_comb begin
    lane_en[0] = (nbytes != 3'd0);
    lane_en[1] = (nbytes >= 3'd2);
    lane_en[2] = (nbytes == 3'd4);
    lane_en[3] = (nbytes == 3'd4);
  end

  // Align write data so the last byte sent comes from wdata[7:0]
  always_comb begin
    case (nbytes)
      3'd1: begin
        lane_data[0] = wdata[7:0];
        lane_data[1] = 8'h00;
        lane_data[2] = 8'h00;
        lane_data[3] = 8'h00;
      end
      3'd2: begin
        lane_data[0] = wdata[15:8];
        lane_data[1] = wdata[7:0];
        lane_data[2] = 8'h00;
        lane_data[3] = 8'h00;
      end
      default: begin
        lane_data[0] = wdata[31:24];
        lane_data[1] = wdata[23:16];
        lane_data[2] = wdata[15:8];
        lane_data[3] = wdata[7:0];
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (beat && rw) begin
      for (int i = 0; i < 4; i++) begin
        if (lane_en[i]) begin
          mem[idx[i]] <= lane_data[i];
        end
      end
    end
  end

  // Zero-extended read for byte and halfword
  always_comb begin
    case (nbytes)
      3'd1:    rdata = {24'h0, mem[idx[0]]};
      3'd2:    rdata = {16'h0, mem[idx[0]], mem[idx[1]]};
      default: rdata = {mem[idx[0]], mem[idx[1]], mem[idx[2]], mem[idx[3]]};
    endcase
  end

endmodule

// File: rtl/mem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory subsystem shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mem_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BEAT_W = 6;

  // Access size codes as driven on the request ports
  typedef enum logic [2:0] {
    SIZE_WORD     = 3'b000,
    SIZE_BURST4   = 3'b001,
    SIZE_BURST8   = 3'b010,
    SIZE_BURST16  = 3'b011,
    SIZE_BYTE     = 3'b100,
    SIZE_HALF     = 3'b101,
    SIZE_ILLEGAL6 = 3'b110,
    SIZE_ILLEGAL7 = 3'b111
  } access_size_t;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BEAT_W-1:0] beat_count_t;

  // Number of beats a request produces, zero for illegal codes
  function automatic beat_count_t beats_for_size(access_size_t size);
    case (size)
      SIZE_WORD:    return 6'd1;
      SIZE_BURST4:  return 6'd4;
      SIZE_BURST8:  return 6'd8;
      SIZE_BURST16: return 6'd16;
      SIZE_BYTE:    return 6'd1;
      SIZE_HALF:    return 6'd1;
      default:      return 6'd0;
    endcase
  endfunction

  // Bytes moved on each beat
  function automatic logic [2:0] bytes_for_size(access_size_t size);
    case (size)
      SIZE_WORD, SIZE_BURST4, SIZE_BURST8, SIZE_BURST16: return 3'd4;
      SIZE_BYTE: return 3'd1;
      SIZE_HALF: return 3'd2;
      default:   return 3'd0;
    endcase
  endfunction

endpackage

// File: rtl/mem_port_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch and data port arbiter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module mem_port_arbiter (
  input  logic                  clk,
  input  logic                  reset,
  // Instruction fetch port
  input  logic                  fetch_en,
  input  mem_pkg::addr_t        fetch_addr,
  input  mem_pkg::access_size_t fetch_size,
  output logic                  fetch_busy,
  output logic                  fetch_valid,
  output mem_pkg::data_t        fetch_rdata,
  output mem_pkg::addr_t        fetch_pc,
  // Data port
  input  logic                  data_en,
  input  logic                  data_rw,
  input  mem_pkg::addr_t        data_addr,
  input  mem_pkg::access_size_t data_size,
  input  mem_pkg::data_t        data_wdata,
  output logic                  data_busy,
  output logic                  data_valid,
  output mem_pkg::data_t        data_rdata,
  // Burst controller side
  output logic                  start,
  output mem_pkg::addr_t        req_addr,
  output logic                  req_rw,
  output mem_pkg::access_size_t req_size,
  output mem_pkg::data_t        req_wdata,
  input  logic                  ready,
  input  logic                  beat,
  input  mem_pkg::data_t        rdata,
  input  mem_pkg::addr_t        pc
);

  // Owner of the current burst, 1 for the data port
  logic owner_data;
  logic grant_data;
  logic grant_fetch;

  // On a tie the port that lost last time goes first
  assign grant_data  = data_en && (!fetch_en || !owner_data);
  assign grant_fetch = fetch_en && !grant_data;

  assign fetch_busy = !ready || grant_data;
  assign data_busy  = !ready || grant_fetch;

  assign start = ready && (grant_data || grant_fetch);

  always_ff @(posedge clk) begin
    if (reset) begin
      owner_data <= 1'b0;
    end else if (start) begin
      owner_data <= grant_data;
    end
  end

  // Request mux, fetch never writes
  assign req_addr = grant_data ? data_addr : fetch_addr;
  assign req_size = grant_data ? data_size : fetch_size;
  assign req_rw   = grant_data && data_rw;

  // Only the data port carries write data
  assign req_wdata = data_wdata;

  // Beat stream goes to the owner alone
  assign fetch_valid = beat && !owner_data;
  assign data_valid  = beat && owner_data;
  assign fetch_rdata = owner_data ? '0 : rdata;
  assign data_rdata  = owner_data ? rdata : '0;
  assign fetch_pc    = owner_data ? '0 : pc;

endmodule

// File: rtl/mem_sys.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory subsystem top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module mem_sys #(
  parameter int             MEM_BYTES  = 1024,
  parameter mem_pkg::addr_t START_ADDR = 32'h8002_0000
) (
  input  logic                  clk,
  input  logic                  reset,
  // Instruction fetch port
  input  logic                  fetch_en,
  input  mem_pkg::addr_t        fetch_addr,
  input  mem_pkg::access_size_t fetch_size,
  output logic                  fetch_busy,
  output logic                  fetch_valid,
  output mem_pkg::data_t        fetch_rdata,
  output mem_pkg::addr_t        fetch_pc,
  // Data port
  input  logic                  data_en,
  input  logic                  data_rw,
  input  mem_pkg::addr_t        data_addr,
  input  mem_pkg::access_size_t data_size,
  input  mem_pkg::data_t        data_wdata,
  output logic                  data_busy,
  output logic                  data_valid,
  output mem_pkg::data_t        data_rdata
);

  logic                  start;
  mem_pkg::addr_t        req_addr;
  logic                  req_rw;
  mem_pkg::access_size_t req_size;
  mem_pkg::data_t        req_wdata;
  logic                  ready;
  logic                  beat;
  logic                  beat_rw;
  mem_pkg::access_size_t beat_size;
  mem_pkg::addr_t        cur_index;
  mem_pkg::data_t        wdata;
  mem_pkg::data_t        rdata;
  mem_pkg::addr_t        pc;

  mem_port_arbiter arbiter_inst (
    .clk         (clk),
    .reset       (reset),
    .fetch_en    (fetch_en),
    .fetch_addr  (fetch_addr),
    .fetch_size  (fetch_size),
    .fetch_busy  (fetch_busy),
    .fetch_valid (fetch_valid),
    .fetch_rdata (fetch_rdata),
    .fetch_pc    (fetch_pc),
    .data_en     (data_en),
    .data_rw     (data_rw),
    .data_addr   (data_addr),
    .data_size   (data_size),
    .data_wdata  (data_wdata),
    .data_busy   (data_busy),
    .data_valid  (data_valid),
    .data_rdata  (data_rdata),
    .start       (start),
    .req_addr    (req_addr),
    .req_rw      (req_rw),
    .req_size    (req_size),
    .req_wdata   (req_wdata),
    .ready       (ready),
    .beat        (beat),
    .rdata       (rdata),
    .pc          (pc)
  );

  mem_burst_ctrl #(
    .START_ADDR (START_ADDR)
  ) burst_ctrl_inst (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .addr      (req_addr),
    .rw        (req_rw),
    .size      (req_size),
    .wdata_in  (req_wdata),
    .ready     (ready),
    .beat      (beat),
    .beat_rw   (beat_rw),
    .beat_size (beat_size),
    .cur_index (cur_index),
    .wdata     (wdata),
    .pc        (pc)
  );

  mem_byte_array #(
    .MEM_BYTES (MEM_BYTES)
  ) byte_array_inst (
    .clk   (clk),
    .beat  (beat),
    .rw    (beat_rw),
    .size  (beat_size),
    .index (cur_index),
    .wdata (wdata),
    .rdata (rdata)
  );

endmodule

// File: verification/mem_sys_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory subsystem testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module mem_sys_tb;

  localparam int             MEM_BYTES    = 256;
  localparam mem_pkg::addr_t START_ADDR   = 32'h8002_0000;
  localparam int             TXN_PER_PORT = 200;
  // Twice the time of all transactions at 18 cycles each
  localparam int             WATCHDOG_NS  = 2 * TXN_PER_PORT * 18 * 8 * 2;

  logic                  clk;
  logic                  reset;
  logic                  fetch_en;
  mem_pkg::addr_t        fetch_addr;
  mem_pkg::access_size_t fetch_size;
  logic                  fetch_busy;
  logic                  fetch_valid;
  mem_pkg::data_t        fetch_rdata;
  mem_pkg::addr_t        fetch_pc;
  logic                  data_en;
  logic                  data_rw;
  mem_pkg::addr_t        data_addr;
  mem_pkg::access_size_t data_size;
  mem_pkg::data_t        data_wdata;
  logic                  data_busy;
  logic                  data_valid;
  mem_pkg::data_t        data_rdata;

  // Reference copy of the storage
  logic [7:0] model_mem [MEM_BYTES];
  logic       last_data;
  logic       seen_accept;

  tb_clock_gen clock_gen_inst (
    .clk   (clk),
    .reset (reset)
  );

  mem_sys #(
    .MEM_BYTES  (MEM_BYTES),
    .START_ADDR (START_ADDR)
  ) mem_sys_inst (
    .clk         (clk),
    .reset       (reset),
    .fetch_en    (fetch_en),
    .fetch_addr  (fetch_addr),
    .fetch_size  (fetch_size),
    .fetch_busy  (fetch_busy),
    .fetch_valid (fetch_valid),
    .fetch_rdata (fetch_rdata),
    .fetch_pc    (fetch_pc),
    .data_en     (data_en),
    .data_rw     (data_rw),
    .data_addr   (data_addr),
    .data_size   (data_size),
    .data_wdata  (data_wdata),
    .data_busy   (data_busy),
    .data_valid  (data_valid),
    .data_rdata  (data_rdata)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_data(input mem_pkg::data_t actual, input mem_pkg::data_t expected,
                            input string what);
    if (actual !== expected) begin
      fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, actual,
                         expected));
    end
  endtask

  task automatic check_addr(input mem_pkg::addr_t actual, input mem_pkg::addr_t expected,
                            input string what);
    if (actual !== expected) begin
      fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, what, actual,
                         expected));
    end
  endtask

  task automatic check_beats(input mem_pkg::beat_count_t actual,
                             input mem_pkg::beat_count_t expected, input string what);
    if (actual !== expected) begin
      fail_run($sformatf("MISMATCH at %0t: %s got %0d expected %0d", $time, what, actual,
                         expected));
    end
  endtask

  // Beats that each size code produces
  function automatic mem_pkg::beat_count_t beat_total(input mem_pkg::access_size_t s);
    case (s)
      mem_pkg::SIZE_BURST4:   return 6'd4;
      mem_pkg::SIZE_BURST8:   return 6'd8;
      mem_pkg::SIZE_BURST16:  return 6'd16;
      mem_pkg::SIZE_ILLEGAL6,
      mem_pkg::SIZE_ILLEGAL7: return 6'd0;
      default:                return 6'd1;
    endcase
  endfunction

  // Rebased byte position wraps at the top of storage
  function automatic int byte_idx(input mem_pkg::addr_t a, input int k);
    mem_pkg::addr_t off;
    off = a - START_ADDR + mem_pkg::addr_t'(k);
    return int'(off & mem_pkg::addr_t'(MEM_BYTES - 1));
  endfunction

  // Big-endian read with zero extension for byte and halfword
  function automatic mem_pkg::data_t model_read(input mem_pkg::addr_t a,
                                                input mem_pkg::access_size_t s);
    case (s)
      mem_pkg::SIZE_BYTE: return {24'h0, model_mem[byte_idx(a, 0)]};
      mem_pkg::SIZE_HALF: return {16'h0, model_mem[byte_idx(a, 0)], model_mem[byte_idx(a, 1)]};
      default: return {model_mem[byte_idx(a, 0)], model_mem[byte_idx(a, 1)],
                       model_mem[byte_idx(a, 2)], model_mem[byte_idx(a, 3)]};
    endcase
  endfunction

  task automatic model_write(input mem_pkg::addr_t a, input mem_pkg::access_size_t s,
                             input mem_pkg::data_t wd);
    case (s)
      mem_pkg::SIZE_BYTE: model_mem[byte_idx(a, 0)] = wd[7:0];
      mem_pkg::SIZE_HALF: begin
        model_mem[byte_idx(a, 0)] = wd[15:8];
        model_mem[byte_idx(a, 1)] = wd[7:0];
      end
      default: begin
        for (int i = 0; i < 4; i++) begin
          model_mem[byte_idx(a, i)] = wd[31-8*i -: 8];
        end
      end
    endcase
  endtask

  function automatic mem_pkg::addr_t rand_addr(input mem_pkg::access_size_t s);
    mem_pkg::addr_t off;
    off = mem_pkg::addr_t'($urandom % MEM_BYTES);
    if (s == mem_pkg::SIZE_HALF) begin
      off[0] = 1'b0;
    end else if (s != mem_pkg::SIZE_BYTE) begin
      off[1:0] = 2'b00;
    end
    return START_ADDR + off;
  endfunction

  // One data port request with wd[k] as the write data of beat k+1
  task automatic data_txn(input logic rw, input mem_pkg::addr_t addr,
                          input mem_pkg::access_size_t size, input mem_pkg::data_t wd [16]);
    int             n;
    int             seen;
    mem_pkg::addr_t beat_addr;
    n    = int'(beat_total(size));
    seen = 0;
    @(posedge clk);
    data_en    <= 1'b1;
    data_rw    <= rw;
    data_addr  <= addr;
    data_size  <= size;
    data_wdata <= wd[0];
    @(negedge clk);
    while (data_busy) @(negedge clk);
    @(posedge clk);
    data_en    <= 1'b0;
    data_wdata <= wd[1];
    for (int k = 1; k <= n + 1; k++) begin
      @(negedge clk);
      if (data_valid && k <= n) begin
        beat_addr = addr + mem_pkg::addr_t'(4 * (k - 1));
        if (rw) begin
          model_write(beat_addr, size, wd[k-1]);
        end else begin
          check_data(data_rdata, model_read(beat_addr, size), "data port read");
        end
      end
      seen += int'(data_valid);
      if (k <= n) begin
        @(posedge clk);
        if (k + 1 < 16) begin
          data_wdata <= wd[k+1];
        end
      end
    end
    check_beats(mem_pkg::beat_count_t'(seen), beat_total(size), "data beats");
  endtask

  task automatic fetch_txn(input mem_pkg::addr_t addr, input mem_pkg::access_size_t size);
    int             n;
    int             seen;
    mem_pkg::addr_t beat_addr;
    n    = int'(beat_total(size));
    seen = 0;
    @(posedge clk);
    fetch_en   <= 1'b1;
    fetch_addr <= addr;
    fetch_size <= size;
    @(negedge clk);
    while (fetch_busy) @(negedge clk);
    @(posedge clk);
    fetch_en <= 1'b0;
    for (int k = 1; k <= n + 1; k++) begin
      @(negedge clk);
      if (fetch_valid && k <= n) begin
        beat_addr = addr + mem_pkg::addr_t'(4 * (k - 1));
        check_addr(fetch_pc, beat_addr, "fetch pc");
        check_data(fetch_rdata, model_read(beat_addr, size), "fetch read");
      end
      seen += int'(fetch_valid);
    end
    check_beats(mem_pkg::beat_count_t'(seen), beat_total(size), "fetch beats");
  endtask

  task automatic data_requests();
    mem_pkg::data_t        wd [16];
    mem_pkg::access_size_t s;
    mem_pkg::addr_t        a;
    for (int i = 0; i < 16; i++) begin
      wd[i] = $urandom;
    end
    // A word, a byte and a halfword written inside one word and read back
    data_txn(1'b1, START_ADDR + 32'd8, mem_pkg::SIZE_WORD, wd);
    data_txn(1'b0, START_ADDR + 32'd8, mem_pkg::SIZE_WORD, wd);
    data_txn(1'b1, START_ADDR + 32'd9, mem_pkg::SIZE_BYTE, wd);
    data_txn(1'b0, START_ADDR + 32'd8, mem_pkg::SIZE_WORD, wd);
    data_txn(1'b1, START_ADDR + 32'd10, mem_pkg::SIZE_HALF, wd);
    data_txn(1'b0, START_ADDR + 32'd10, mem_pkg::SIZE_HALF, wd);
    for (int t = 6; t < TXN_PER_PORT; t++) begin
      for (int i = 0; i < 16; i++) begin
        wd[i] = $urandom;
      end
      s = mem_pkg::access_size_t'(3'($urandom_range(7, 0)));
      a = rand_addr(s);
      data_txn(1'($urandom_range(1, 0)), a, s, wd);
      repeat ($urandom_range(2, 0)) @(posedge clk);
    end
  endtask

  task automatic fetch_requests();
    mem_pkg::access_size_t s;
    for (int t = 0; t < TXN_PER_PORT; t++) begin
      case ($urandom_range(5, 0))
        0:       s = mem_pkg::SIZE_WORD;
        1:       s = mem_pkg::SIZE_BURST4;
        2:       s = mem_pkg::SIZE_BURST8;
        3:       s = mem_pkg::SIZE_BURST16;
        4:       s = mem_pkg::SIZE_ILLEGAL6;
        default: s = mem_pkg::SIZE_ILLEGAL7;
      endcase
      fetch_txn(rand_addr(s), s);
      repeat ($urandom_range(2, 0)) @(posedge clk);
    end
  endtask

  // Reset behavior and round-robin grants seen from outside
  always @(negedge clk) begin
    if (!reset) begin
      if (!seen_accept && (fetch_valid !== 1'b0 || data_valid !== 1'b0)) begin
        fail_run("a valid output went high before the first accepted request");
      end
      if (fetch_en && data_en) begin
        if (!fetch_busy && !data_busy) begin
          fail_run("both ports were granted in the same cycle");
        end
        if (!fetch_busy && !last_data) begin
          fail_run("fetch port won a tie twice in a row");
        end
        if (!data_busy && last_data) begin
          fail_run("data port won a tie twice in a row");
        end
      end
      if (data_en && !data_busy) begin
        last_data   = 1'b1;
        seen_accept = 1'b1;
      end else if (fetch_en && !fetch_busy) begin
        last_data   = 1'b0;
        seen_accept = 1'b1;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    fail_run("watchdog timeout, the requests did not finish in time");
  end

  initial begin
    mem_pkg::data_t wd [16];
    void'($urandom(7));
    last_data   = 1'b0;
    seen_accept = 1'b0;
    fetch_en    = 1'b0;
    fetch_addr  = START_ADDR;
    fetch_size  = mem_pkg::SIZE_WORD;
    data_en     = 1'b0;
    data_rw     = 1'b0;
    data_addr   = START_ADDR;
    data_size   = mem_pkg::SIZE_WORD;
    data_wdata  = '0;
    while (reset !== 1'b0) @(posedge clk);
    // Fill all of storage so every later read has known bytes
    for (int b = 0; b < MEM_BYTES / 64; b++) begin
      for (int i = 0; i < 16; i++) begin
        wd[i] = mem_pkg::data_t'((b * 64 + i * 4) * 32'h9E37_79B1) ^ 32'h5A5A_0000;
      end
      data_txn(1'b1, START_ADDR + mem_pkg::addr_t'(b * 64), mem_pkg::SIZE_BURST16, wd);
    end
    fork
      fetch_requests();
      data_requests();
    join
    @(posedge clk);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: verification/tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
  end

  // 8 ns period
  always #4 clk = ~clk;

  initial begin
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  end

endmodule
